/* project.f */
+incdir+.
vdp_pkg.sv
vdp_cfg_if.sv
vdp_csr.sv
vdp_ctrl.sv
vdp_dot_tree.sv
vdp_accel.sv
vdp_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f project.f --top-module vdp_tb -o vdp_sim

out=$(./obj_dir/vdp_sim)
echo "$out"

# The run counts as passed only if the pass line is present
echo "$out" | grep -qx "No errors"

exit 0

/* vdp_tb.sv */
`default_nettype none

`include "vdp_consts.svh"

module vdp_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_ROWS = 4;
  localparam int TIMEOUT_CYCLES = NUM_ROWS * 300 + 100;

  logic        clk_i;
  logic        reset_i;
  logic        io_cmd_v_i;
  logic        io_cmd_we_i;
  logic [19:0] io_cmd_addr_i;
  logic [63:0] io_cmd_data_i;
  logic        io_resp_v_o;
  logic        io_resp_we_o;
  logic [19:0] io_resp_addr_o;
  logic [63:0] io_resp_data_o;
  logic        mem_req_v_o;
  logic        mem_req_we_o;
  logic [63:0] mem_req_addr_o;
  logic [63:0] mem_req_data_o;
  logic        mem_req_ready_i;
  logic        mem_resp_v_i;
  logic [63:0] mem_resp_data_i;

  // Job table
  logic [63:0] row_a_ptr [NUM_ROWS];
  logic [63:0] row_b_ptr [NUM_ROWS];
  logic [63:0] row_res_ptr [NUM_ROWS];
  logic [63:0] row_len [NUM_ROWS];
  logic [63:0] row_a [NUM_ROWS][8];
  logic [63:0] row_b [NUM_ROWS][8];
  logic [63:0] row_exp [NUM_ROWS];
  logic        row_poke [NUM_ROWS];

  logic [63:0] mem [logic [63:0]];
  logic [63:0] load_log [$];
  int          store_count;
  logic [63:0] last_store_addr;
  logic [31:0] rng;
  int          errors;

  vdp_accel i_vdp_accel (.*);

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic int eff_len(input logic [63:0] len);
    return (len > 64'd8) ? 8 : int'(len);
  endfunction

  // Sum of products over the active lanes modulo 2^64
  function automatic logic [63:0] expected_dot(input int r);
    logic [63:0] sum;
    sum = '0;
    for (int i = 0; i < eff_len(row_len[r]); i++) begin
      sum = sum + row_a[r][i] * row_b[r][i];
    end
    return sum;
  endfunction

  task automatic build_table();
    logic [63:0] lens [NUM_ROWS];
    lens = '{64'd3, 64'd8, 64'd0, 64'd12};
    for (int r = 0; r < NUM_ROWS; r++) begin
      row_a_ptr[r]   = 64'h1000_0000 + 64'(r) * 64'h1000;
      row_b_ptr[r]   = 64'h2000_0000 + 64'(r) * 64'h1000;
      row_res_ptr[r] = 64'h3000_0000 + 64'(r) * 64'h1000;
      row_len[r]     = lens[r];
      row_poke[r]    = (r == 1);
      for (int i = 0; i < 8; i++) begin
        rng = lcg_next(rng);
        row_a[r][i] = {rng, rng ^ 32'h5a5a_0f0f};
        rng = lcg_next(rng);
        row_b[r][i] = {~rng, rng};
      end
      row_exp[r] = expected_dot(r);
    end
  endtask

  // One host command; the response must come exactly one cycle later
  task automatic reg_access(input logic we, input logic [19:0] addr,
                            input logic [63:0] wdata, output logic [63:0] rdata);
    @(posedge clk_i);
    io_cmd_v_i    <= 1'b1;
    io_cmd_we_i   <= we;
    io_cmd_addr_i <= addr;
    io_cmd_data_i <= wdata;
    @(posedge clk_i);
    io_cmd_v_i <= 1'b0;
    if (io_resp_v_o !== 1'b0) begin
      errors++;
      $display("CHECK FAILED at %0t: response too early for addr %h", $time, addr);
    end
    @(posedge clk_i);
    rdata = io_resp_data_o;
    if (io_resp_v_o !== 1'b1 || io_resp_we_o !== we || io_resp_addr_o !== addr) begin
      errors++;
      $display("CHECK FAILED at %0t: bad response echo for addr %h", $time, addr);
    end
    if (we && io_resp_data_o !== 64'd0) begin
      errors++;
      $display("CHECK FAILED at %0t: write response data %h", $time, io_resp_data_o);
    end
  endtask

  task automatic reg_write(input logic [19:0] addr, input logic [63:0] data);
    logic [63:0] unused;
    reg_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_check(input logic [19:0] addr, input logic [63:0] exp);
    logic [63:0] got;
    reg_access(1'b0, addr, '0, got);
    if (got !== exp) begin
      errors++;
      $display("CHECK FAILED at %0t: reg %h read %h, expected %h", $time, addr, got, exp);
    end
  endtask

  task automatic run_row(input int r);
    logic [63:0] status;
    int          n;
    for (int i = 0; i < 8; i++) begin
      mem[row_a_ptr[r] + 64'(i) * 8] = row_a[r][i];
      mem[row_b_ptr[r] + 64'(i) * 8] = row_b[r][i];
    end
    reg_write(`VDP_REG_A_PTR, row_a_ptr[r]);
    reg_write(`VDP_REG_B_PTR, row_b_ptr[r]);
    reg_write(`VDP_REG_LEN, row_len[r]);
    reg_write(`VDP_REG_RES_PTR, row_res_ptr[r]);
    load_log.delete();
    store_count = 0;
    reg_write(`VDP_REG_START, 64'd1);
    reg_check(`VDP_REG_STATUS, 64'd0);
    if (row_poke[r]) begin
      reg_write(`VDP_REG_A_PTR, 64'hdead_0000);
      reg_write(`VDP_REG_START, 64'd1);
    end
    reg_access(1'b0, `VDP_REG_STATUS, '0, status);
    while (status !== 64'd1) begin
      reg_access(1'b0, `VDP_REG_STATUS, '0, status);
    end
    n = eff_len(row_len[r]);
    if (store_count != 1 || last_store_addr !== row_res_ptr[r]) begin
      errors++;
      $display("CHECK FAILED at %0t: row %0d saw %0d stores, last at %h", $time, r,
               store_count, last_store_addr);
    end
    if (mem[row_res_ptr[r]] !== row_exp[r]) begin
      errors++;
      $display("CHECK FAILED at %0t: row %0d result %h, expected %h", $time, r,
               mem[row_res_ptr[r]], row_exp[r]);
    end
    if (load_log.size() != 2 * n) begin
      errors++;
      $display("CHECK FAILED at %0t: row %0d made %0d loads, expected %0d", $time, r,
               load_log.size(), 2 * n);
    end else begin
      for (int i = 0; i < n; i++) begin
        if (load_log[i] !== row_a_ptr[r] + 64'(i) * 8 ||
            load_log[n + i] !== row_b_ptr[r] + 64'(i) * 8) begin
          errors++;
          $display("CHECK FAILED at %0t: row %0d load order wrong at element %0d", $time,
                   r, i);
        end
      end
    end
    reg_check(`VDP_REG_A_PTR, row_a_ptr[r]);
  endtask

  // Memory model with random ready and one to four cycles of response delay
  always @(posedge clk_i) begin
    static int          delay = -1;
    static logic [63:0] pend_addr = '0;
    mem_resp_v_i <= 1'b0;
    rng = lcg_next(rng);
    mem_req_ready_i <= (rng[18:17] != 2'b00);
    if (!reset_i) begin
      if (delay > 0) begin
        delay--;
      end else if (delay == 0) begin
        mem_resp_v_i    <= 1'b1;
        mem_resp_data_i <= mem.exists(pend_addr) ? mem[pend_addr] : ~pend_addr;
        delay = -1;
      end else if (mem_req_v_o && mem_req_ready_i) begin
        pend_addr = mem_req_addr_o;
        if (mem_req_we_o) begin
          mem[mem_req_addr_o] = mem_req_data_o;
          store_count++;
          last_store_addr = mem_req_addr_o;
        end else begin
          load_log.push_back(mem_req_addr_o);
        end
        delay = int'(rng[24:23]);
      end
    end
  end

  initial begin
    #(TIMEOUT_CYCLES * 100);
    $display("Timeout: the DUT hung and the run was stopped");
    $display("Errors found");
    $finish;
  end

  initial begin
    clk_i           = 1'b0;
    reset_i         = 1'b1;
    io_cmd_v_i      = 1'b0;
    io_cmd_we_i     = 1'b0;
    io_cmd_addr_i   = '0;
    io_cmd_data_i   = '0;
    mem_req_ready_i = 1'b0;
    mem_resp_v_i    = 1'b0;
    mem_resp_data_i = '0;
    errors          = 0;
    store_count     = 0;
    last_store_addr = '0;
    rng             = 32'h4a5e;
    build_table();
    repeat (5) @(posedge clk_i);
    reset_i <= 1'b0;
    reg_check(`VDP_REG_STATUS, 64'd1);
    reg_write(`VDP_REG_A_PTR, 64'h0123_4567_89ab_cdef);
    reg_check(`VDP_REG_A_PTR, 64'h0123_4567_89ab_cdef);
    reg_write(`VDP_REG_LEN, 64'd21);
    reg_check(`VDP_REG_LEN, 64'd21);
    reg_check(20'h300, 64'd0);
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(r);
    end
    $display("%0d errors counted", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* vdp_accel.sv */
`default_nettype none

`include "vdp_consts.svh"

module vdp_accel (
  input  wire                        clk_i,
  input  wire                        reset_i,

  // Host register port
  input  wire                        io_cmd_v_i,
  input  wire                        io_cmd_we_i,
  input  wire [`VDP_CSR_ADDR_W-1:0]  io_cmd_addr_i,
  input  wire vdp_pkg::word_t        io_cmd_data_i,
  output logic                       io_resp_v_o,
  output logic                       io_resp_we_o,
  output logic [`VDP_CSR_ADDR_W-1:0] io_resp_addr_o,
  output vdp_pkg::word_t             io_resp_data_o,

  // External memory port
  output logic                       mem_req_v_o,
  output logic                       mem_req_we_o,
  output vdp_pkg::word_t             mem_req_addr_o,
  output vdp_pkg::word_t             mem_req_data_o,
  input  wire                        mem_req_ready_i,
  input  wire                        mem_resp_v_i,
  input  wire vdp_pkg::word_t        mem_resp_data_i
);

  vdp_cfg_if cfg ();

  logic           dot_in_v;
  vdp_pkg::vec_t  dot_a;
  vdp_pkg::vec_t  dot_b;
  logic           dot_out_v;
  vdp_pkg::word_t dot_res;

  vdp_csr i_csr (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .io_cmd_v_i     (io_cmd_v_i),
    .io_cmd_we_i    (io_cmd_we_i),
    .io_cmd_addr_i  (io_cmd_addr_i),
    .io_cmd_data_i  (io_cmd_data_i),
    .io_resp_v_o    (io_resp_v_o),
    .io_resp_we_o   (io_resp_we_o),
    .io_resp_addr_o (io_resp_addr_o),
    .io_resp_data_o (io_resp_data_o),
    .cfg            (cfg.csr)
  );

  vdp_ctrl i_ctrl (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .cfg             (cfg.ctrl),
    .mem_req_v_o     (mem_req_v_o),
    .mem_req_we_o    (mem_req_we_o),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_req_data_o  (mem_req_data_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_resp_v_i    (mem_resp_v_i),
    .mem_resp_data_i (mem_resp_data_i),
    .dot_v_o         (dot_in_v),
    .dot_a_o         (dot_a),
    .dot_b_o         (dot_b),
    .dot_v_i         (dot_out_v),
    .dot_res_i       (dot_res)
  );

  vdp_dot_tree i_dot_tree (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .in_v_i  (dot_in_v),
    .a_i     (dot_a),
    .b_i     (dot_b),
    .out_v_o (dot_out_v),
    .res_o   (dot_res)
  );

endmodule

`default_nettype wire

/* vdp_dot_tree.sv */
`default_nettype none

`include "vdp_consts.svh"

module vdp_dot_tree (
  input  wire                clk_i,
  input  wire                reset_i,
  input  wire                in_v_i,
  input  wire vdp_pkg::vec_t a_i,
  input  wire vdp_pkg::vec_t b_i,
  output logic               out_v_o,
  output vdp_pkg::word_t     res_o
);

  vdp_pkg::word_t prod_r [`VDP_DEPTH];
  vdp_pkg::word_t sum_l1 [`VDP_DEPTH/2];
  vdp_pkg::word_t sum_l2 [`VDP_DEPTH/4];
  vdp_pkg::word_t sum_all;
  logic           v1_r;
  logic           v2_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v1_r <= 1'b0;
      v2_r <= 1'b0;
    end else begin
      v1_r <= in_v_i;
      v2_r <= v1_r;
    end
  end

  // Stage one keeps the low 64 bits of each product
  always_ff @(posedge clk_i) begin
    if (in_v_i) begin
      for (int i = 0; i < `VDP_DEPTH; i++) begin
        prod_r[i] <= a_i[i] * b_i[i];
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `VDP_DEPTH/2; i++) begin
      sum_l1[i] = prod_r[2*i] + prod_r[2*i+1];
    end
    for (int i = 0; i < `VDP_DEPTH/4; i++) begin
      sum_l2[i] = sum_l1[2*i] + sum_l1[2*i+1];
    end
    sum_all = sum_l2[0] + sum_l2[1];
  end

  // Stage two
  always_ff @(posedge clk_i) begin
    if (v1_r) begin
      res_o <= sum_all;
    end
  end

  assign out_v_o = v2_r;

endmodule

`default_nettype wire

/* vdp_ctrl.sv */
`default_nettype none

module vdp_ctrl (
  input  wire                 clk_i,
  input  wire                 reset_i,

  vdp_cfg_if.ctrl             cfg,

  output logic                mem_req_v_o,
  output logic                mem_req_we_o,
  output vdp_pkg::word_t      mem_req_addr_o,
  output vdp_pkg::word_t      mem_req_data_o,
  input  wire                 mem_req_ready_i,
  input  wire                 mem_resp_v_i,
  input  wire vdp_pkg::word_t mem_resp_data_i,

  output logic                dot_v_o,
  output vdp_pkg::vec_t       dot_a_o,
  output vdp_pkg::vec_t       dot_b_o,
  input  wire                 dot_v_i,
  input  wire vdp_pkg::word_t dot_res_i
);

  typedef enum logic [2:0] {
    e_idle,
    e_load_a,
    e_wait_a,
    e_load_b,
    e_wait_b,
    e_compute,
    e_store,
    e_wait_ack
  } state_e;

  state_e         state_r;
  state_e         state_n;
  vdp_pkg::len_t  idx_r;
  vdp_pkg::len_t  idx_next;
  logic           last_elem;
  logic           load_done;
  vdp_pkg::vec_t  a_buf_r;
  vdp_pkg::vec_t  b_buf_r;
  vdp_pkg::word_t res_r;
  vdp_pkg::word_t elem_off;
  logic           dot_v_r;

  assign idx_next  = idx_r + 4'd1;
  assign last_elem = (idx_next == cfg.len);
  assign load_done = mem_resp_v_i && (state_r == e_wait_a || state_r == e_wait_b);

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_idle: begin
        if (cfg.start) begin
          // Empty job goes straight to the tree with cleared buffers
          state_n = (cfg.len == '0) ? e_compute : e_load_a;
        end
      end
      e_load_a:   if (mem_req_ready_i) state_n = e_wait_a;
      e_wait_a:   if (mem_resp_v_i) state_n = last_elem ? e_load_b : e_load_a;
      e_load_b:   if (mem_req_ready_i) state_n = e_wait_b;
      e_wait_b:   if (mem_resp_v_i) state_n = last_elem ? e_compute : e_load_b;
      e_compute:  if (dot_v_i) state_n = e_store;
      e_store:    if (mem_req_ready_i) state_n = e_wait_ack;
      e_wait_ack: if (mem_resp_v_i) state_n = e_idle;
      default:    state_n = e_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_idle;
      idx_r   <= '0;
      dot_v_r <= 1'b0;
    end else begin
      state_r <= state_n;
      // One operand pair per job goes out on entry to compute
      dot_v_r <= (state_n == e_compute) && (state_r != e_compute);
      if (state_r == e_idle) begin
        idx_r <= '0;
      end else if (load_done) begin
        idx_r <= last_elem ? '0 : idx_next;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_r == e_idle && cfg.start) begin
      a_buf_r <= '0;
      b_buf_r <= '0;
    end else if (state_r == e_wait_a && mem_resp_v_i) begin
      a_buf_r[idx_r[2:0]] <= mem_resp_data_i;
    end else if (state_r == e_wait_b && mem_resp_v_i) begin
      b_buf_r[idx_r[2:0]] <= mem_resp_data_i;
    end
    if (state_r == e_compute && dot_v_i) begin
      res_r <= dot_res_i;
    end
  end

  // Byte offset of the current element
  assign elem_off = vdp_pkg::word_t'(idx_r) << 3;

  always_comb begin
    mem_req_v_o  = (state_r == e_load_a) || (state_r == e_load_b) || (state_r == e_store);
    mem_req_we_o = (state_r == e_store);
    case (state_r)
      e_load_b: mem_req_addr_o = cfg.b_ptr + elem_off;
      e_store:  mem_req_addr_o = cfg.res_ptr;
      default:  mem_req_addr_o = cfg.a_ptr + elem_off;
    endcase
    mem_req_data_o = mem_req_we_o ? res_r : '0;
  end

  assign cfg.busy = (state_r != e_idle);
  assign dot_v_o  = dot_v_r;
  assign dot_a_o  = a_buf_r;
  assign dot_b_o  = b_buf_r;

endmodule

`default_nettype wire

/* vdp_csr.sv */
`default_nettype none

`include "vdp_consts.svh"

module vdp_csr (
  input  wire                        clk_i,
  input  wire                        reset_i,

  input  wire                        io_cmd_v_i,
  input  wire                        io_cmd_we_i,
  input  wire [`VDP_CSR_ADDR_W-1:0]  io_cmd_addr_i,
  input  wire vdp_pkg::word_t        io_cmd_data_i,

  output logic                       io_resp_v_o,
  output logic                       io_resp_we_o,
  output logic [`VDP_CSR_ADDR_W-1:0] io_resp_addr_o,
  output vdp_pkg::word_t             io_resp_data_o,

  vdp_cfg_if.csr                     cfg
);

  vdp_pkg::word_t a_ptr_r;
  vdp_pkg::word_t b_ptr_r;
  vdp_pkg::word_t len_r;
  vdp_pkg::word_t start_r;
  vdp_pkg::word_t res_ptr_r;
  logic           start_pulse_r;
  logic           idle;
  logic           wr_v;
  logic           rd_v;
  vdp_pkg::word_t rd_data;

  // Still busy in the cycle the start pulse is on its way to the controller
  assign idle = ~cfg.busy & ~start_pulse_r;
  assign wr_v = io_cmd_v_i & io_cmd_we_i;
  assign rd_v = io_cmd_v_i & ~io_cmd_we_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_r       <= '0;
      b_ptr_r       <= '0;
      len_r         <= '0;
      start_r       <= '0;
      res_ptr_r     <= '0;
      start_pulse_r <= 1'b0;
      io_resp_v_o   <= 1'b0;
    end else begin
      io_resp_v_o   <= io_cmd_v_i;
      start_pulse_r <= wr_v & idle & (io_cmd_addr_i == `VDP_REG_START)
                       & (io_cmd_data_i != '0);
      // Settings are frozen for the length of a job
      if (wr_v && idle) begin
        case (io_cmd_addr_i)
          `VDP_REG_A_PTR:   a_ptr_r   <= io_cmd_data_i;
          `VDP_REG_B_PTR:   b_ptr_r   <= io_cmd_data_i;
          `VDP_REG_LEN:     len_r     <= io_cmd_data_i;
          `VDP_REG_START:   start_r   <= io_cmd_data_i;
          `VDP_REG_RES_PTR: res_ptr_r <= io_cmd_data_i;
          default: begin
          end
        endcase
      end
    end
  end

  always_comb begin
    case (io_cmd_addr_i)
      `VDP_REG_A_PTR:   rd_data = a_ptr_r;
      `VDP_REG_B_PTR:   rd_data = b_ptr_r;
      `VDP_REG_LEN:     rd_data = len_r;
      `VDP_REG_START:   rd_data = start_r;
      `VDP_REG_STATUS:  rd_data = vdp_pkg::word_t'(idle);
      `VDP_REG_RES_PTR: rd_data = res_ptr_r;
      default:          rd_data = '0;
    endcase
  end

  // Response echoes the command one cycle later
  always_ff @(posedge clk_i) begin
    if (io_cmd_v_i) begin
      io_resp_we_o   <= io_cmd_we_i;
      io_resp_addr_o <= io_cmd_addr_i;
      io_resp_data_o <= rd_v ? rd_data : '0;
    end
  end

  assign cfg.a_ptr   = a_ptr_r;
  assign cfg.b_ptr   = b_ptr_r;
  assign cfg.res_ptr = res_ptr_r;
  assign cfg.start   = start_pulse_r;

  // Lengths beyond the buffer depth run as a full vector
  assign cfg.len = (len_r > `VDP_DEPTH) ? vdp_pkg::len_t'(`VDP_DEPTH) : len_r[3:0];

endmodule

`default_nettype wire

/* vdp_cfg_if.sv */
`default_nettype none

interface vdp_cfg_if;

  // Job settings from the register block
  vdp_pkg::word_t a_ptr;
  vdp_pkg::word_t b_ptr;
  vdp_pkg::word_t res_ptr;
  vdp_pkg::len_t  len;
  logic           start;

  // High while a job is in flight
  logic           busy;

  modport csr (
    output a_ptr,
    output b_ptr,
    output res_ptr,
    output len,
    output start,
    input  busy
  );

  modport ctrl (
    input  a_ptr,
    input  b_ptr,
    input  res_ptr,
    input  len,
    input  start,
    output busy
  );

endinterface

`default_nettype wire

/* vdp_pkg.sv */
`default_nettype none

`include "vdp_consts.svh"

package vdp_pkg;

  // One data word or byte address
  typedef logic [`VDP_WORD_W-1:0] word_t;

  // Element count from 0 to 8
  typedef logic [3:0] len_t;

  // One operand vector with element i in lane i
  typedef word_t [`VDP_DEPTH-1:0] vec_t;

endpackage

`default_nettype wire

/* vdp_consts.svh */
`ifndef VDP_CONSTS_SVH
`define VDP_CONSTS_SVH

// Vector geometry
`define VDP_DEPTH       8
`define VDP_WORD_W      64

// Width of the register offset on the command port
`define VDP_CSR_ADDR_W  20

// Register offsets
`define VDP_REG_A_PTR   20'h000
`define VDP_REG_B_PTR   20'h040
`define VDP_REG_LEN     20'h080
`define VDP_REG_START   20'h0C0
`define VDP_REG_STATUS  20'h100
`define VDP_REG_RES_PTR 20'h140

`endif
